// File: sources.f
+incdir+include
rtl/la_pipe_pkg.sv
rtl/la_isa_pkg.sv
rtl/basic_decoder.sv
rtl/decoder.sv
rtl/fetch_decode_queue.sv
rtl/decode_stage.sv
sim/decode_stage_sva.sv
sim/decode_stage_tb.sv

// File: sim/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

    typedef struct packed {
        la_pipe_pkg::inst_t    inst;
        la_pipe_pkg::arfid_t   r0;
        la_pipe_pkg::arfid_t   r1;
        la_pipe_pkg::arfid_t   w;
        logic [1:0]            need;     // {second read, first read}
        logic [1:0]            use_imm;
        logic [2:0]            flags;    // {w_reg, w_mem, decode_err}
        la_pipe_pkg::imm_t     imm;      // data imm if used, else address imm
        la_isa_pkg::op_class_t cls;
        la_isa_pkg::alu_op_t   alu;
    } inst_exp_t;

    typedef struct packed {
        logic [3:0]              i0;     // index into inst_tab
        logic [3:0]              i1;
        la_pipe_pkg::slot_mask_t mask;
        la_pipe_pkg::pc_t        pc;
    } pkt_t;

    logic                                                   clk;
    logic                                                   rst;
    logic                                                   in_valid;
    logic                                                   in_ready;
    la_pipe_pkg::inst_t    [la_pipe_pkg::DECODE_WIDTH-1:0]   in_insts;
    la_pipe_pkg::pc_t                                       in_pc;
    la_pipe_pkg::slot_mask_t                                in_mask;
    logic                                                   out_valid;
    logic                                                   out_ready;
    la_pipe_pkg::pc_t      [la_pipe_pkg::DECODE_WIDTH-1:0]   out_pc;
    la_pipe_pkg::arfid_t   [2*la_pipe_pkg::DECODE_WIDTH-1:0] out_r_arfid;
    la_pipe_pkg::arfid_t   [la_pipe_pkg::DECODE_WIDTH-1:0]   out_w_arfid;
    logic [2*la_pipe_pkg::DECODE_WIDTH-1:0]                  out_reg_need;
    logic [2*la_pipe_pkg::DECODE_WIDTH-1:0]                  out_use_imm;
    logic [la_pipe_pkg::DECODE_WIDTH-1:0]                    out_w_reg;
    logic [la_pipe_pkg::DECODE_WIDTH-1:0]                    out_w_mem;
    la_pipe_pkg::imm_t     [la_pipe_pkg::DECODE_WIDTH-1:0]   out_data_imm;
    la_pipe_pkg::imm_t     [la_pipe_pkg::DECODE_WIDTH-1:0]   out_addr_imm;
    la_isa_pkg::op_class_t [la_pipe_pkg::DECODE_WIDTH-1:0]   out_op_class;
    la_isa_pkg::alu_op_t   [la_pipe_pkg::DECODE_WIDTH-1:0]   out_alu_op;
    logic [la_pipe_pkg::DECODE_WIDTH-1:0]                    out_decode_err;
    la_pipe_pkg::slot_mask_t                                out_slot_valid;

    inst_exp_t inst_tab[$];
    pkt_t      pkt_tab[$];
    logic      ready_pat [256];   // out_ready pattern, drawn at time 0
    int        cyc;
    int        rx_count;

    decode_stage #(
        .QUEUE_DEPTH (2)
    ) u_decode_stage (.*);

    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_arfid(input string name, input la_pipe_pkg::arfid_t exp, act);
        if (act !== exp)
            fail_run($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_imm(input string name, input la_pipe_pkg::imm_t exp, act);
        if (act !== exp)
            fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_pc(input string name, input la_pipe_pkg::pc_t exp, act);
        if (act !== exp)
            fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flags(input string name, input logic [2:0] exp, act);
        if (act !== exp)
            fail_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_op_class(input string name, input la_isa_pkg::op_class_t exp, act);
        if (act !== exp)
            fail_run($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_alu_op(input string name, input la_isa_pkg::alu_op_t exp, act);
        if (act !== exp)
            fail_run($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic add_inst(
        input la_pipe_pkg::inst_t    inst,
        input la_pipe_pkg::arfid_t   r0, r1, w,
        input logic [1:0]            need, use_imm,
        input logic [2:0]            flags,
        input la_pipe_pkg::imm_t     imm,
        input la_isa_pkg::op_class_t cls,
        input la_isa_pkg::alu_op_t   alu
    );
        inst_tab.push_back(inst_exp_t'{inst, r0, r1, w, need, use_imm, flags, imm, cls, alu});
    endtask

    task automatic build_tables();
        add_inst(32'h001018a4, 5'd5, 5'd6, 5'd4, 2'b11, 2'b00, 3'b100, 32'h0,   // add.w
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_ADD);
        add_inst(32'h00112507, 5'd8, 5'd9, 5'd7, 2'b11, 2'b00, 3'b100, 32'h0,   // sub.w
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_SUB);
        add_inst(32'h0014b16a, 5'd11, 5'd12, 5'd10, 2'b11, 2'b00, 3'b100, 32'h0,
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_AND);
        add_inst(32'h00153dcd, 5'd14, 5'd15, 5'd13, 2'b11, 2'b00, 3'b100, 32'h0,
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_OR);
        add_inst(32'h02bffc41, 5'd2, 5'd0, 5'd1, 2'b11, 2'b10, 3'b100, 32'hffffffff, // addi -1
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_ADD);
        add_inst(32'h03a000c5, 5'd6, 5'd0, 5'd5, 2'b11, 2'b10, 3'b100, 32'h00000800, // ori
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_OR);
        add_inst(32'h00409462, 5'd3, 5'd0, 5'd2, 2'b11, 2'b10, 3'b100, 32'h5,   // slli.w
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_SLL);
        add_inst(32'h15000028, 5'd0, 5'd0, 5'd8, 2'b10, 2'b10, 3'b100, 32'h80001000,
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_LUI);
        add_inst(32'h28bfe149, 5'd10, 5'd0, 5'd9, 2'b11, 2'b10, 3'b100, 32'hfffffff8, // ld.w
                 la_isa_pkg::CLASS_LSU, la_isa_pkg::ALU_ADD);
        add_inst(32'h2980418b, 5'd12, 5'd11, 5'd0, 2'b11, 2'b00, 3'b010, 32'h10, // st.w
                 la_isa_pkg::CLASS_LSU, la_isa_pkg::ALU_ADD);
        add_inst(32'h5bfffdae, 5'd13, 5'd14, 5'd0, 2'b11, 2'b00, 3'b000, 32'hfffffffc,
                 la_isa_pkg::CLASS_BRANCH, la_isa_pkg::ALU_SUB);
        add_inst(32'h54010000, 5'd0, 5'd0, 5'd1, 2'b00, 2'b00, 3'b100, 32'h100, // bl forward
                 la_isa_pkg::CLASS_BRANCH, la_isa_pkg::ALU_ADD);
        add_inst(32'h57fffbff, 5'd0, 5'd0, 5'd1, 2'b00, 2'b00, 3'b100, 32'hfffffff8,
                 la_isa_pkg::CLASS_BRANCH, la_isa_pkg::ALU_ADD);
        add_inst(32'hffffffff, 5'd0, 5'd0, 5'd0, 2'b00, 2'b00, 3'b001, 32'h0,   // no match
                 la_isa_pkg::CLASS_ILLEGAL, la_isa_pkg::ALU_ADD);
        add_inst(32'h029ffeb4, 5'd21, 5'd0, 5'd20, 2'b11, 2'b10, 3'b100, 32'h7ff,
                 la_isa_pkg::CLASS_ALU, la_isa_pkg::ALU_ADD);

        pkt_tab.push_back(pkt_t'{4'd0, 4'd1, 2'b11, 32'h1c000000});
        pkt_tab.push_back(pkt_t'{4'd2, 4'd3, 2'b11, 32'h1c000008});
        pkt_tab.push_back(pkt_t'{4'd4, 4'd5, 2'b11, 32'h1c000010});
        pkt_tab.push_back(pkt_t'{4'd6, 4'd7, 2'b11, 32'h1c000018});
        pkt_tab.push_back(pkt_t'{4'd8, 4'd9, 2'b11, 32'h1c000020});
        pkt_tab.push_back(pkt_t'{4'd10, 4'd11, 2'b11, 32'h1c000028});
        pkt_tab.push_back(pkt_t'{4'd12, 4'd13, 2'b11, 32'h1c000030});
        pkt_tab.push_back(pkt_t'{4'd14, 4'd0, 2'b11, 32'h00001238});
        pkt_tab.push_back(pkt_t'{4'd13, 4'd13, 2'b11, 32'h00001240});
        pkt_tab.push_back(pkt_t'{4'd5, 4'd13, 2'b01, 32'h00001248}); // slot 1 masked off
        pkt_tab.push_back(pkt_t'{4'd1, 4'd2, 2'b01, 32'h8000fff8});
        pkt_tab.push_back(pkt_t'{4'd7, 4'd8, 2'b11, 32'h80010000});
        pkt_tab.push_back(pkt_t'{4'd9, 4'd10, 2'b11, 32'h80010008});
        pkt_tab.push_back(pkt_t'{4'd11, 4'd14, 2'b11, 32'h80010010});
    endtask

    task automatic check_pkt(input int n);
        string     tag;
        inst_exp_t e;
        tag = $sformatf("pkt%0d", n);
        check_flags({tag, " slot_valid"}, 3'(pkt_tab[n].mask), 3'(out_slot_valid));
        check_pc({tag, " pc0"}, pkt_tab[n].pc, out_pc[0]);
        check_pc({tag, " pc1"}, pkt_tab[n].pc | 32'h4, out_pc[1]);
        for (int s = 0; s < la_pipe_pkg::DECODE_WIDTH; s++) begin
            if (pkt_tab[n].mask[s]) begin
                e = (s == 0) ? inst_tab[pkt_tab[n].i0] : inst_tab[pkt_tab[n].i1];
                tag = $sformatf("pkt%0d slot%0d", n, s);
                check_arfid({tag, " r0_arfid"}, e.r0, out_r_arfid[2*s]);
                check_arfid({tag, " r1_arfid"}, e.r1, out_r_arfid[2*s+1]);
                check_arfid({tag, " w_arfid"}, e.w, out_w_arfid[s]);
                check_flags({tag, " reg_need"}, 3'(e.need), 3'(out_reg_need[2*s +: 2]));
                check_flags({tag, " use_imm"}, 3'(e.use_imm), 3'(out_use_imm[2*s +: 2]));
                check_flags({tag, " wreg_wmem_err"}, e.flags,
                            {out_w_reg[s], out_w_mem[s], out_decode_err[s]});
                check_op_class({tag, " op_class"}, e.cls, out_op_class[s]);
                if (e.cls == la_isa_pkg::CLASS_ALU)
                    check_alu_op({tag, " alu_op"}, e.alu, out_alu_op[s]);
                if (e.use_imm[1])
                    check_imm({tag, " data_imm"}, e.imm, out_data_imm[s]);
                if (e.cls == la_isa_pkg::CLASS_LSU || e.cls == la_isa_pkg::CLASS_BRANCH)
                    check_imm({tag, " addr_imm"}, e.imm, out_addr_imm[s]);
            end
        end
    endtask

    // holds the packet until in_ready, then checks the empty-queue latency
    task automatic send_pkt(input int i);
        logic was_empty;
        in_valid    = 1'b1;
        in_insts[0] = inst_tab[pkt_tab[i].i0].inst;
        in_insts[1] = inst_tab[pkt_tab[i].i1].inst;
        in_pc       = pkt_tab[i].pc;
        in_mask     = pkt_tab[i].mask;
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        was_empty = !out_valid;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (was_empty && !out_valid)
            fail_run($sformatf("packet %0d not on out_valid one cycle after acceptance", i));
    endtask

    always @(posedge clk) begin
        #1;
        out_ready = ready_pat[cyc % 256];
        cyc = cyc + 1;
    end

    // transfers are sampled on the edge, before any register update
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (rx_count >= pkt_tab.size()) begin
                fail_run("DUT handed on a packet that was never sent");
            end else begin
                check_pkt(rx_count);
                rx_count = rx_count + 1;
            end
        end
    end

    initial begin
        #1;
        repeat (pkt_tab.size() * 20) @(posedge clk);
        fail_run($sformatf("timeout with %0d of %0d packets received", rx_count,
                           pkt_tab.size()));
    end

    initial begin
        void'($urandom(32'hf674));
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_insts  = '0;
        in_pc     = '0;
        in_mask   = '0;
        out_ready = 1'b0;
        cyc       = 0;
        rx_count  = 0;
        build_tables();
        foreach (ready_pat[k])
            ready_pat[k] = ($urandom_range(3) != 0);   // ready about 3 of 4 cycles
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < pkt_tab.size(); i++) begin
            repeat ($urandom_range(2)) begin
                @(posedge clk);
                #1;
            end
            send_pkt(i);
        end
        wait (rx_count == pkt_tab.size());
        repeat (5) @(posedge clk);
        if (rx_count == pkt_tab.size()) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("packet count changed after the last packet");
        end
    end

endmodule

// File: sim/decode_stage_sva.sv
`timescale 1ns/1ps

module decode_stage_sva #(
    parameter int QUEUE_DEPTH = 2
) (
    input logic                                                 clk,
    input logic                                                 rst,
    input logic                                                 in_valid,
    input logic                                                 in_ready,
    input logic                                                 out_valid,
    input logic                                                 out_ready,
    input la_pipe_pkg::pc_t    [la_pipe_pkg::DECODE_WIDTH-1:0]   out_pc,
    input la_pipe_pkg::arfid_t [2*la_pipe_pkg::DECODE_WIDTH-1:0] out_r_arfid,
    input la_pipe_pkg::arfid_t [la_pipe_pkg::DECODE_WIDTH-1:0]   out_w_arfid,
    input la_pipe_pkg::imm_t   [la_pipe_pkg::DECODE_WIDTH-1:0]   out_data_imm,
    input la_pipe_pkg::imm_t   [la_pipe_pkg::DECODE_WIDTH-1:0]   out_addr_imm,
    input la_pipe_pkg::slot_mask_t                              out_slot_valid
);

    int pending;   // accepted but not yet handed on

    always_ff @(posedge clk) begin
        if (rst)
            pending <= 0;
        else
            pending <= pending + int'(in_valid && in_ready) - int'(out_valid && out_ready);
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable({out_pc, out_r_arfid, out_w_arfid,
                                                          out_data_imm, out_addr_imm,
                                                          out_slot_valid}))
        else $error("decode output changed while stalled");

    a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid && in_ready)
        else $error("out_valid high or in_ready low after reset");

    a_full_only: assert property (@(posedge clk) disable iff (rst)
        !in_ready |-> pending == QUEUE_DEPTH)
        else $error("in_ready low with queue not full");

endmodule

bind decode_stage decode_stage_sva #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_decode_stage_sva (.*);

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   in_valid,
    output logic                                                   in_ready,
    input  la_pipe_pkg::inst_t  [la_pipe_pkg::DECODE_WIDTH-1:0]    in_insts,
    input  la_pipe_pkg::pc_t                                       in_pc,
    input  la_pipe_pkg::slot_mask_t                                in_mask,
    output logic                                                   out_valid,
    input  logic                                                   out_ready,
    output la_pipe_pkg::pc_t    [la_pipe_pkg::DECODE_WIDTH-1:0]    out_pc,
    output la_pipe_pkg::arfid_t [2*la_pipe_pkg::DECODE_WIDTH-1:0]  out_r_arfid,
    output la_pipe_pkg::arfid_t [la_pipe_pkg::DECODE_WIDTH-1:0]    out_w_arfid,
    output logic [2*la_pipe_pkg::DECODE_WIDTH-1:0]                 out_reg_need,
    output logic [2*la_pipe_pkg::DECODE_WIDTH-1:0]                 out_use_imm,
    output logic [la_pipe_pkg::DECODE_WIDTH-1:0]                   out_w_reg,
    output logic [la_pipe_pkg::DECODE_WIDTH-1:0]                   out_w_mem,
    output la_pipe_pkg::imm_t   [la_pipe_pkg::DECODE_WIDTH-1:0]    out_data_imm,
    output la_pipe_pkg::imm_t   [la_pipe_pkg::DECODE_WIDTH-1:0]    out_addr_imm,
    output la_isa_pkg::op_class_t [la_pipe_pkg::DECODE_WIDTH-1:0]  out_op_class,
    output la_isa_pkg::alu_op_t [la_pipe_pkg::DECODE_WIDTH-1:0]    out_alu_op,
    output logic [la_pipe_pkg::DECODE_WIDTH-1:0]                   out_decode_err,
    output la_pipe_pkg::slot_mask_t                                out_slot_valid
);

    // queue to decoder
    logic                                               q_valid;
    logic                                               q_ready;
    la_pipe_pkg::inst_t [la_pipe_pkg::DECODE_WIDTH-1:0] q_insts;
    la_pipe_pkg::pc_t                                   q_pc;
    la_pipe_pkg::slot_mask_t                            q_mask;

    fetch_decode_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_decode_queue (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_insts (in_insts),
        .in_pc    (in_pc),
        .in_mask  (in_mask),
        .q_valid  (q_valid),
        .q_ready  (q_ready),
        .q_insts  (q_insts),
        .q_pc     (q_pc),
        .q_mask   (q_mask)
    );

    decoder u_decoder (
        .q_valid        (q_valid),
        .q_ready        (q_ready),
        .q_insts        (q_insts),
        .q_pc           (q_pc),
        .q_mask         (q_mask),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_pc         (out_pc),
        .out_r_arfid    (out_r_arfid),
        .out_w_arfid    (out_w_arfid),
        .out_reg_need   (out_reg_need),
        .out_use_imm    (out_use_imm),
        .out_w_reg      (out_w_reg),
        .out_w_mem      (out_w_mem),
        .out_data_imm   (out_data_imm),
        .out_addr_imm   (out_addr_imm),
        .out_op_class   (out_op_class),
        .out_alu_op     (out_alu_op),
        .out_decode_err (out_decode_err),
        .out_slot_valid (out_slot_valid)
    );

endmodule

// File: rtl/fetch_decode_queue.sv
`timescale 1ns/1ps

module fetch_decode_queue #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                in_valid,
    output logic                                                in_ready,
    input  la_pipe_pkg::inst_t [la_pipe_pkg::DECODE_WIDTH-1:0]  in_insts,
    input  la_pipe_pkg::pc_t                                    in_pc,
    input  la_pipe_pkg::slot_mask_t                             in_mask,
    output logic                                                q_valid,
    input  logic                                                q_ready,
    output la_pipe_pkg::inst_t [la_pipe_pkg::DECODE_WIDTH-1:0]  q_insts,
    output la_pipe_pkg::pc_t                                    q_pc,
    output la_pipe_pkg::slot_mask_t                             q_mask
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    la_pipe_pkg::inst_t [la_pipe_pkg::DECODE_WIDTH-1:0] insts_mem [QUEUE_DEPTH];
    la_pipe_pkg::pc_t        pc_mem   [QUEUE_DEPTH];
    la_pipe_pkg::slot_mask_t mask_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push, pop;

    assign in_ready = count < CNT_W'(QUEUE_DEPTH);
    assign q_valid  = count != '0;
    assign push     = in_valid & in_ready;
    assign pop      = q_valid & q_ready;

    // head entry straight out
    assign q_insts = insts_mem[rd_ptr];
    assign q_pc    = pc_mem[rd_ptr];
    assign q_mask  = mask_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            insts_mem[wr_ptr] <= in_insts;
            pc_mem[wr_ptr]    <= in_pc;
            mask_mem[wr_ptr]  <= in_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1; // both at once leaves count as is
        end
    end

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                                                   q_valid,
    output logic                                                   q_ready,
    input  la_pipe_pkg::inst_t  [la_pipe_pkg::DECODE_WIDTH-1:0]    q_insts,
    input  la_pipe_pkg::pc_t                                       q_pc,
    input  la_pipe_pkg::slot_mask_t                                q_mask,
    output logic                                                   out_valid,
    input  logic                                                   out_ready,
    output la_pipe_pkg::pc_t    [la_pipe_pkg::DECODE_WIDTH-1:0]    out_pc,
    output la_pipe_pkg::arfid_t [2*la_pipe_pkg::DECODE_WIDTH-1:0]  out_r_arfid,
    output la_pipe_pkg::arfid_t [la_pipe_pkg::DECODE_WIDTH-1:0]    out_w_arfid,
    output logic [2*la_pipe_pkg::DECODE_WIDTH-1:0]                 out_reg_need,
    output logic [2*la_pipe_pkg::DECODE_WIDTH-1:0]                 out_use_imm,
    output logic [la_pipe_pkg::DECODE_WIDTH-1:0]                   out_w_reg,
    output logic [la_pipe_pkg::DECODE_WIDTH-1:0]                   out_w_mem,
    output la_pipe_pkg::imm_t   [la_pipe_pkg::DECODE_WIDTH-1:0]    out_data_imm,
    output la_pipe_pkg::imm_t   [la_pipe_pkg::DECODE_WIDTH-1:0]    out_addr_imm,
    output la_isa_pkg::op_class_t [la_pipe_pkg::DECODE_WIDTH-1:0]  out_op_class,
    output la_isa_pkg::alu_op_t [la_pipe_pkg::DECODE_WIDTH-1:0]    out_alu_op,
    output logic [la_pipe_pkg::DECODE_WIDTH-1:0]                   out_decode_err,
    output la_pipe_pkg::slot_mask_t                                out_slot_valid
);

    `include "imm_funcs.svh"

    // imm and zero selects both read r0
    function automatic la_pipe_pkg::arfid_t sel_arfid(
        input la_isa_pkg::reg_sel_t sel,
        input la_pipe_pkg::inst_t   inst
    );
        case (sel)
            la_isa_pkg::REG_RD: return inst[4:0];
            la_isa_pkg::REG_RJ: return inst[9:5];
            la_isa_pkg::REG_RK: return inst[14:10];
            default:            return '0;
        endcase
    endfunction

    // no state here, handshake passes straight through
    assign out_valid      = q_valid;
    assign q_ready        = out_ready;
    assign out_slot_valid = q_mask;

    for (genvar i = 0; i < la_pipe_pkg::DECODE_WIDTH; i++) begin : g_slot
        la_isa_pkg::reg_sel_t  r0_sel;
        la_isa_pkg::reg_sel_t  r1_sel;
        la_isa_pkg::wreg_sel_t w_sel;
        la_isa_pkg::data_imm_t data_kind;
        la_isa_pkg::addr_imm_t addr_kind;

        basic_decoder u_basic_decoder (
            .inst          (q_insts[i]),
            .r0_sel        (r0_sel),
            .r1_sel        (r1_sel),
            .w_sel         (w_sel),
            .data_imm_kind (data_kind),
            .addr_imm_kind (addr_kind),
            .op_class      (out_op_class[i]),
            .alu_op        (out_alu_op[i]),
            .mem_write     (out_w_mem[i]),
            .decode_err    (out_decode_err[i])
        );

        assign out_pc[i] = q_pc | la_pipe_pkg::pc_t'(i * 4); // slot 1 sets bit 2

        assign out_r_arfid[2*i]   = sel_arfid(r0_sel, q_insts[i]);
        assign out_r_arfid[2*i+1] = sel_arfid(r1_sel, q_insts[i]);
        assign out_reg_need[2*i]   = r0_sel != la_isa_pkg::REG_ZERO;
        assign out_reg_need[2*i+1] = r1_sel != la_isa_pkg::REG_ZERO;
        assign out_use_imm[2*i]    = r0_sel == la_isa_pkg::REG_IMM;
        assign out_use_imm[2*i+1]  = r1_sel == la_isa_pkg::REG_IMM;

        always_comb begin
            case (w_sel)
                la_isa_pkg::WREG_RD: out_w_arfid[i] = q_insts[i][4:0];
                la_isa_pkg::WREG_R1: out_w_arfid[i] = 5'd1; // bl link
                default:             out_w_arfid[i] = '0;
            endcase
        end
        assign out_w_reg[i] = w_sel != la_isa_pkg::WREG_NONE;

        assign out_data_imm[i] = inst_to_data_imm(q_insts[i], data_kind);
        assign out_addr_imm[i] = inst_to_addr_imm(q_insts[i], addr_kind);
    end

endmodule

// File: rtl/basic_decoder.sv
`timescale 1ns/1ps

module basic_decoder (
    input  la_pipe_pkg::inst_t      inst,
    output la_isa_pkg::reg_sel_t    r0_sel,
    output la_isa_pkg::reg_sel_t    r1_sel,
    output la_isa_pkg::wreg_sel_t   w_sel,
    output la_isa_pkg::data_imm_t   data_imm_kind,
    output la_isa_pkg::addr_imm_t   addr_imm_kind,
    output la_isa_pkg::op_class_t   op_class,
    output la_isa_pkg::alu_op_t     alu_op,
    output logic                    mem_write,
    output logic                    decode_err
);

    logic [16:0] opc17;
    logic [9:0]  opc10;
    logic [6:0]  opc7;
    logic [5:0]  opc6;
    logic        is_3r;

    assign opc17 = inst[31:15];
    assign opc10 = inst[31:22];
    assign opc7  = inst[31:25];
    assign opc6  = inst[31:26];

    // register-register group shares all selects
    assign is_3r = (opc17 == la_isa_pkg::OPC_ADD_W) || (opc17 == la_isa_pkg::OPC_SUB_W) ||
                   (opc17 == la_isa_pkg::OPC_AND)   || (opc17 == la_isa_pkg::OPC_OR);

    always_comb begin
        // unmatched word falls through as illegal
        r0_sel        = la_isa_pkg::REG_ZERO;
        r1_sel        = la_isa_pkg::REG_ZERO;
        w_sel         = la_isa_pkg::WREG_NONE;
        data_imm_kind = la_isa_pkg::IMM_S12;
        addr_imm_kind = la_isa_pkg::ADDR_S12;
        op_class      = la_isa_pkg::CLASS_ILLEGAL;
        alu_op        = la_isa_pkg::ALU_ADD;
        mem_write     = 1'b0;
        decode_err    = 1'b1;

        if (is_3r) begin
            r0_sel     = la_isa_pkg::REG_RJ;
            r1_sel     = la_isa_pkg::REG_RK;
            w_sel      = la_isa_pkg::WREG_RD;
            op_class   = la_isa_pkg::CLASS_ALU;
            decode_err = 1'b0;
            case (opc17)
                la_isa_pkg::OPC_SUB_W: alu_op = la_isa_pkg::ALU_SUB;
                la_isa_pkg::OPC_AND:   alu_op = la_isa_pkg::ALU_AND;
                la_isa_pkg::OPC_OR:    alu_op = la_isa_pkg::ALU_OR;
                default:               alu_op = la_isa_pkg::ALU_ADD;
            endcase
        end else if (opc17 == la_isa_pkg::OPC_SLLI_W) begin
            r0_sel        = la_isa_pkg::REG_RJ;
            r1_sel        = la_isa_pkg::REG_IMM;
            w_sel         = la_isa_pkg::WREG_RD;
            data_imm_kind = la_isa_pkg::IMM_U5;
            op_class      = la_isa_pkg::CLASS_ALU;
            alu_op        = la_isa_pkg::ALU_SLL;
            decode_err    = 1'b0;
        end else if (opc10 == la_isa_pkg::OPC_ADDI_W || opc10 == la_isa_pkg::OPC_ORI) begin
            r0_sel     = la_isa_pkg::REG_RJ;
            r1_sel     = la_isa_pkg::REG_IMM;
            w_sel      = la_isa_pkg::WREG_RD;
            op_class   = la_isa_pkg::CLASS_ALU;
            decode_err = 1'b0;
            if (opc10 == la_isa_pkg::OPC_ORI) begin
                data_imm_kind = la_isa_pkg::IMM_U12; // logical op, zero extended
                alu_op        = la_isa_pkg::ALU_OR;
            end
        end else if (opc10 == la_isa_pkg::OPC_LD_W) begin
            r0_sel     = la_isa_pkg::REG_RJ;   // base
            r1_sel     = la_isa_pkg::REG_IMM;
            w_sel      = la_isa_pkg::WREG_RD;
            op_class   = la_isa_pkg::CLASS_LSU;
            decode_err = 1'b0;
        end else if (opc10 == la_isa_pkg::OPC_ST_W) begin
            r0_sel     = la_isa_pkg::REG_RJ;   // base
            r1_sel     = la_isa_pkg::REG_RD;   // store data
            op_class   = la_isa_pkg::CLASS_LSU;
            mem_write  = 1'b1;
            decode_err = 1'b0;
        end else if (opc7 == la_isa_pkg::OPC_LU12I_W) begin
            r1_sel        = la_isa_pkg::REG_IMM;
            w_sel         = la_isa_pkg::WREG_RD;
            data_imm_kind = la_isa_pkg::IMM_S20H;
            op_class      = la_isa_pkg::CLASS_ALU;
            alu_op        = la_isa_pkg::ALU_LUI;
            decode_err    = 1'b0;
        end else if (opc6 == la_isa_pkg::OPC_BEQ) begin
            r0_sel        = la_isa_pkg::REG_RJ;
            r1_sel        = la_isa_pkg::REG_RD;
            addr_imm_kind = la_isa_pkg::ADDR_S16;
            op_class      = la_isa_pkg::CLASS_BRANCH;
            alu_op        = la_isa_pkg::ALU_SUB; // compare by subtract
            decode_err    = 1'b0;
        end else if (opc6 == la_isa_pkg::OPC_BL) begin
            w_sel         = la_isa_pkg::WREG_R1; // link gets pc + 4
            addr_imm_kind = la_isa_pkg::ADDR_S26;
            op_class      = la_isa_pkg::CLASS_BRANCH;
            decode_err    = 1'b0;
        end
    end

endmodule

// File: rtl/la_isa_pkg.sv
package la_isa_pkg;

    // where a read operand comes from
    typedef enum logic [2:0] {
        REG_ZERO,   // no register, reads r0
        REG_RD,
        REG_RJ,
        REG_RK,
        REG_IMM     // operand replaced by immediate
    } reg_sel_t;

    typedef enum logic [1:0] {
        WREG_NONE,
        WREG_RD,
        WREG_R1     // link register, bl only
    } wreg_sel_t;

    typedef enum logic [1:0] {
        IMM_S12,    // si12 sign extended
        IMM_U12,    // ui12 zero extended
        IMM_U5,     // shift amount
        IMM_S20H    // si20 into bits 31:12
    } data_imm_t;

    typedef enum logic [1:0] {
        ADDR_S12,   // load/store offset, no shift
        ADDR_S16,   // beq offs16 << 2
        ADDR_S26    // bl offs26 << 2
    } addr_imm_t;

    typedef enum logic [1:0] {
        CLASS_ALU,
        CLASS_LSU,
        CLASS_BRANCH,
        CLASS_ILLEGAL
    } op_class_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLL,
        ALU_LUI
    } alu_op_t;

    // fixed opcode fields, 3R and 2RI5 forms use inst[31:15]
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    // 2RI12 forms use inst[31:22]
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_ORI    = 10'h00e;
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;   // inst[31:25]
    localparam logic [5:0]  OPC_BEQ    = 6'h16;    // inst[31:26]
    localparam logic [5:0]  OPC_BL     = 6'h15;

endpackage

// File: rtl/la_pipe_pkg.sv
package la_pipe_pkg;

    // two slots per fetch packet, decoder logic assumes this
    localparam int DECODE_WIDTH = 2;

    typedef logic [31:0] pc_t;     // byte address
    typedef logic [31:0] inst_t;   // raw instruction word
    typedef logic [4:0]  arfid_t;  // architectural GPR index
    typedef logic [31:0] imm_t;    // immediate after extension

    // one valid bit per slot
    typedef logic [DECODE_WIDTH-1:0] slot_mask_t;

endpackage

// File: include/imm_funcs.svh
`ifndef IMM_FUNCS_SVH
`define IMM_FUNCS_SVH

// data immediate, rd field never contributes
function automatic la_pipe_pkg::imm_t inst_to_data_imm(
    input la_pipe_pkg::inst_t    inst,
    input la_isa_pkg::data_imm_t kind
);
    la_pipe_pkg::imm_t ret;
    case (kind)
        la_isa_pkg::IMM_U12:  ret = {20'b0, inst[21:10]};
        la_isa_pkg::IMM_U5:   ret = {27'b0, inst[14:10]};
        la_isa_pkg::IMM_S20H: ret = {inst[24:5], 12'b0};   // lu12i.w
        default:              ret = {{20{inst[21]}}, inst[21:10]};
    endcase
    return ret;
endfunction

// address immediate for load/store and branch targets
function automatic la_pipe_pkg::imm_t inst_to_addr_imm(
    input la_pipe_pkg::inst_t    inst,
    input la_isa_pkg::addr_imm_t kind
);
    la_pipe_pkg::imm_t ret;
    case (kind)
        la_isa_pkg::ADDR_S16: ret = {{14{inst[25]}}, inst[25:10], 2'b0};
        // offs26 is split, high part sits in inst[9:0]
        la_isa_pkg::ADDR_S26: ret = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
        default:              ret = {{20{inst[21]}}, inst[21:10]};
    endcase
    return ret;
endfunction

`endif
